// ==== video_pkg.sv ====
`default_nettype none

package video_pkg;

	// width of one colour channel
	localparam int color_bits = 6;

	// line memory address, up to 1024 pixels per line
	localparam int addr_bits = 10;

	// ce_pix period counter, periods up to 15 clocks
	localparam int rate_bits = 4;

	// pixel index into one bank of the line memory
	typedef logic [addr_bits-1:0] addr_t;

	// one rgb pixel, 18 bits
	typedef struct packed {
		logic [color_bits-1:0] r;
		logic [color_bits-1:0] g;
		logic [color_bits-1:0] b;
	} pixel_t;

	// write side position, driven once per input pixel
	typedef struct packed {
		addr_t x;
		logic bank;
		logic en;
	} wr_pos_t;

	// read side position, driven once per output pixel
	typedef struct packed {
		addr_t x;
		logic bank;
		// set while the line is shown for the second time
		logic second;
		logic en;
	} rd_pos_t;

endpackage

`default_nettype wire

// ==== pix_rate_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module pix_rate_gen (
	input wire logic clk_sys,
	input wire logic reset,
	input wire logic ce_pix,
	output logic ce_x2
);

	// clocks since the last ce_pix, saturating
	logic [video_pkg::rate_bits-1:0] cnt;
	// clocks between the last two ce_pix strobes
	logic [video_pkg::rate_bits-1:0] period;
	// number of strobes seen since reset, stops at 2
	logic [1:0] seen;
	logic [video_pkg::rate_bits-1:0] half;
	logic mid;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cnt <= '0;
			period <= '0;
			seen <= '0;
		end else if (ce_pix) begin
			// cnt is 1 on the clock right after a strobe
			cnt <= {{(video_pkg::rate_bits-1){1'b0}}, 1'b1};
			period <= cnt;
			if (seen != 2'd2)
				seen <= seen + 2'd1;
		end else if (cnt != '1) begin
			cnt <= cnt + 1'b1;
		end
	end

	// truncated half period, odd periods place the extra clock after the midpoint
	assign half = {1'b0, period[video_pkg::rate_bits-1:1]};

	// the period is only meaningful once two strobes have been measured
	// a half period of zero means ce_pix already runs every clock
	assign mid = seen[1] & ~ce_pix & (half != '0) & (cnt == half);

	// first pulse rides on ce_pix itself, second one sits midway
	assign ce_x2 = ce_pix | mid;

endmodule

`default_nettype wire

// ==== line_timing.sv ====
`timescale 1ns/1ns
`default_nettype none

module line_timing (
	input wire logic clk_sys,
	input wire logic reset,
	input wire logic ce_pix,
	input wire logic ce_x2,
	input wire logic hs_in,
	output logic hs_out,
	output video_pkg::wr_pos_t wr_pos,
	output video_pkg::rd_pos_t rd_pos
);

	// hs_in as sampled on the previous ce_pix
	logic hs_d;
	// index of the next input pixel in the current line
	video_pkg::addr_t hcnt;
	// rise position of the line in progress
	video_pkg::addr_t rise_pos;
	// rise position and last index of the previous complete line
	video_pkg::addr_t hs_rise;
	video_pkg::addr_t line_last;
	// output counter value after the next ce_x2
	video_pkg::addr_t out_next;
	logic hs_fall;
	logic hs_up;
	logic out_wrap;

	// edges are only seen on pixel strobes
	assign hs_fall = ce_pix & hs_d & ~hs_in;
	assign hs_up = ce_pix & ~hs_d & hs_in;

	// the output line ends at the stored length, or early on an input line start
	// so that output stays locked to input even if the line length changes
	assign out_wrap = hs_fall | (rd_pos.x == line_last);
	assign out_next = out_wrap ? '0 : rd_pos.x + 1'b1;

	// input side, runs on ce_pix
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hs_d <= 1'b0;
			hcnt <= '0;
			rise_pos <= '0;
			hs_rise <= '0;
			// no line measured yet, let the output counter run the full range
			line_last <= '1;
			wr_pos <= '0;
		end else begin
			wr_pos.en <= 1'b0;
			if (ce_pix) begin
				hs_d <= hs_in;
				// every strobe is written, including the one that starts a line
				wr_pos.en <= 1'b1;
				if (hs_fall) begin
					// falling hsync starts a line, hcnt holds the length of the old one
					line_last <= hcnt - 1'b1;
					hs_rise <= rise_pos;
					// new line goes to the other bank at index 0
					wr_pos.x <= '0;
					wr_pos.bank <= ~wr_pos.bank;
					hcnt <= video_pkg::addr_t'(1);
				end else begin
					wr_pos.x <= hcnt;
					hcnt <= hcnt + 1'b1;
				end
				if (hs_up)
					rise_pos <= hcnt;
			end
		end
	end

	// output side, runs on ce_x2
	// one output line is one input line length in ce_x2 strobes, so half the time
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hs_out <= 1'b0;
			rd_pos <= '0;
		end else begin
			rd_pos.en <= 1'b0;
			if (ce_x2) begin
				rd_pos.en <= 1'b1;
				rd_pos.x <= out_next;
				// same sync position as the input, in half the time
				if (out_next == '0)
					hs_out <= 1'b0;
				else if (out_next == hs_rise)
					hs_out <= 1'b1;
				if (hs_fall) begin
					// input line start, show the line that just finished
					// wr_pos.bank still names that bank in this cycle
					rd_pos.second <= 1'b0;
					rd_pos.bank <= wr_pos.bank;
				end else if (out_wrap) begin
					rd_pos.second <= ~rd_pos.second;
					// back to a first copy, take whichever bank is not written
					if (rd_pos.second)
						rd_pos.bank <= ~wr_pos.bank;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== line_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module line_store (
	input wire logic clk_sys,
	input wire logic we,
	input wire logic wbank,
	input wire video_pkg::addr_t waddr,
	input wire video_pkg::pixel_t wdata,
	input wire video_pkg::addr_t raddr,
	output video_pkg::pixel_t rdata_a,
	output video_pkg::pixel_t rdata_b
);

	// one array per bank, each a simple dual port ram
	video_pkg::pixel_t mem_a [2**video_pkg::addr_bits];
	video_pkg::pixel_t mem_b [2**video_pkg::addr_bits];

	// bank 0
	always_ff @(posedge clk_sys) begin
		if (we && !wbank)
			mem_a[waddr] <= wdata;
		rdata_a <= mem_a[raddr];
	end

	// bank 1
	// both banks are read at the same address so the blend needs one access
	always_ff @(posedge clk_sys) begin
		if (we && wbank)
			mem_b[waddr] <= wdata;
		rdata_b <= mem_b[raddr];
	end

endmodule

`default_nettype wire

// ==== line_doubler.sv ====
`timescale 1ns/1ns
`default_nettype none

module line_doubler (
	input wire logic clk_sys,
	input wire logic reset,
	input wire logic smooth,
	input wire video_pkg::wr_pos_t wr_pos,
	input wire video_pkg::rd_pos_t rd_pos,
	input wire video_pkg::pixel_t pix_in,
	output video_pkg::pixel_t pix_out
);

	// pix_in as it was on the ce_pix clock, the write strobe comes one clock later
	video_pkg::pixel_t pix_hold;
	video_pkg::pixel_t rdata_a;
	video_pkg::pixel_t rdata_b;
	video_pkg::pixel_t cur;
	video_pkg::pixel_t blend;
	// read strobe, bank and blend select aligned with the memory output
	logic en_d;
	logic bank_d;
	logic blend_d;

	// truncated per channel mean of two pixels
	function automatic video_pkg::pixel_t mean(
		input video_pkg::pixel_t a,
		input video_pkg::pixel_t b
	);
		logic [video_pkg::color_bits:0] sum_r;
		logic [video_pkg::color_bits:0] sum_g;
		logic [video_pkg::color_bits:0] sum_b;
		video_pkg::pixel_t res;
		sum_r = {1'b0, a.r} + {1'b0, b.r};
		sum_g = {1'b0, a.g} + {1'b0, b.g};
		sum_b = {1'b0, a.b} + {1'b0, b.b};
		res.r = sum_r[video_pkg::color_bits:1];
		res.g = sum_g[video_pkg::color_bits:1];
		res.b = sum_b[video_pkg::color_bits:1];
		return res;
	endfunction

	always_ff @(posedge clk_sys) begin
		pix_hold <= pix_in;
	end

	line_store u_store (
		.clk_sys (clk_sys),
		.we      (wr_pos.en),
		.wbank   (wr_pos.bank),
		.waddr   (wr_pos.x),
		.wdata   (pix_hold),
		.raddr   (rd_pos.x),
		.rdata_a (rdata_a),
		.rdata_b (rdata_b)
	);

	// first stage is the registered read inside line_store
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			en_d <= 1'b0;
			bank_d <= 1'b0;
			blend_d <= 1'b0;
		end else begin
			en_d <= rd_pos.en;
			bank_d <= rd_pos.bank;
			blend_d <= smooth & rd_pos.second;
		end
	end

	assign cur = bank_d ? rdata_b : rdata_a;

	// on the second copy the other bank already holds the incoming line up to
	// well past this x, so the blend falls between the shown line and the next
	assign blend = mean(rdata_a, rdata_b);

	// second stage, same depth whether blended or not
	always_ff @(posedge clk_sys) begin
		if (reset)
			pix_out <= '0;
		else if (en_d)
			pix_out <= blend_d ? blend : cur;
	end

endmodule

`default_nettype wire

// ==== scandoubler.sv ====
`timescale 1ns/1ns
`default_nettype none

module scandoubler (
	input wire logic clk_sys,
	input wire logic reset,
	input wire logic ce_pix,
	input wire logic hs_in,
	input wire logic vs_in,
	input wire logic smooth,
	input wire video_pkg::pixel_t pix_in,
	output logic hs_out,
	output logic vs_out,
	output video_pkg::pixel_t pix_out
);

	// double rate pixel strobe
	logic ce_x2;
	// write and read positions into the line memory
	video_pkg::wr_pos_t wr_pos;
	video_pkg::rd_pos_t rd_pos;

	// vsync is not realigned, a frame keeps its input line count in time
	assign vs_out = vs_in;

	pix_rate_gen u_rate (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ce_pix  (ce_pix),
		.ce_x2   (ce_x2)
	);

	// hsync and memory positions
	line_timing u_timing (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ce_pix  (ce_pix),
		.ce_x2   (ce_x2),
		.hs_in   (hs_in),
		.hs_out  (hs_out),
		.wr_pos  (wr_pos),
		.rd_pos  (rd_pos)
	);

	// pixel path, two clocks from rd_pos.en to pix_out
	line_doubler u_doubler (
		.clk_sys (clk_sys),
		.reset   (reset),
		.smooth  (smooth),
		.wr_pos  (wr_pos),
		.rd_pos  (rd_pos),
		.pix_in  (pix_in),
		.pix_out (pix_out)
	);

endmodule

`default_nettype wire

// ==== scandoubler_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module timing_chk (
	input wire logic clk_sys,
	input wire logic reset,
	input wire logic ce_x2,
	input wire video_pkg::wr_pos_t wr_pos,
	input wire video_pkg::rd_pos_t rd_pos
);

	// strobes are cleared by the edge that samples reset
	reset_clears_strobes: assert property (
		@(posedge clk_sys) reset |=> (!wr_pos.en && !rd_pos.en)
	) else $error("memory strobe high while reset is asserted");

	// no read strobe without a ce_x2 on the clock before
	read_only_on_ce: assert property (
		@(posedge clk_sys) disable iff (reset) !ce_x2 |=> !rd_pos.en
	) else $error("read strobe without a ce_x2 on the clock before");

endmodule

bind line_timing timing_chk u_chk (
	.clk_sys (clk_sys),
	.reset   (reset),
	.ce_x2   (ce_x2),
	.wr_pos  (wr_pos),
	.rd_pos  (rd_pos)
);

`default_nettype wire

// ==== scandoubler_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module scandoubler_tb;

	// input line geometry, in pixels
	localparam int active_px = 64;
	localparam int sync_px = 8;
	localparam int line_px = active_px + sync_px;
	// one ce_pix every four clocks
	localparam int clk_per_px = 4;
	localparam int line_clocks = line_px * clk_per_px;
	// an output line is line_px ce_x2 strobes, two clocks apart
	localparam int out_line_clocks = line_px * 2;
	localparam int num_lines = 13;
	localparam int timeout_cycles = num_lines * line_clocks + 400;

	logic clk_sys;
	logic reset;
	logic ce_pix;
	logic hs_in;
	logic vs_in;
	logic smooth;
	video_pkg::pixel_t pix_in;
	logic hs_out;
	logic vs_out;
	video_pkg::pixel_t pix_out;

	int pix_errors;
	int sync_errors;
	int cycle_cnt = 0;
	int line_no;
	// clock count at the last hs_out fall, -1 before the first one
	int last_fall;
	logic hs_prev;
	// line shown on the output and line being written
	video_pkg::pixel_t prev_line [active_px];
	video_pkg::pixel_t cur_line [active_px];

	scandoubler DUT (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ce_pix  (ce_pix),
		.hs_in   (hs_in),
		.vs_in   (vs_in),
		.smooth  (smooth),
		.pix_in  (pix_in),
		.hs_out  (hs_out),
		.vs_out  (vs_out),
		.pix_out (pix_out)
	);

	// 40 ns clock
	always #20 clk_sys = ~clk_sys;

	// hard stop a little past the expected run length
	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= timeout_cycles) begin
			$display("run stopped at the clock limit of %0d cycles", timeout_cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	task automatic compare_pixel(
		input string name,
		input video_pkg::pixel_t want,
		input video_pkg::pixel_t got
	);
		if (got !== want) begin
			pix_errors++;
			$display("Mismatch at %0t ns: %s expected %h got %h", $time, name, want, got);
		end
	endtask

	task automatic compare_bit(input string name, input logic want, input logic got);
		if (got !== want) begin
			sync_errors++;
			$display("Mismatch at %0t ns: %s expected %b got %b", $time, name, want, got);
		end
	endtask

	// clock spacings and edge counts
	task automatic compare_count(input string name, input int want, input int got);
		if (got != want) begin
			sync_errors++;
			$display("Mismatch at %0t ns: %s expected %0d got %0d", $time, name, want, got);
		end
	endtask

	// per channel mean, rounded down
	function automatic video_pkg::pixel_t avg_pixel(
		input video_pkg::pixel_t a,
		input video_pkg::pixel_t b
	);
		int s;
		video_pkg::pixel_t res;
		s = (int'(a.r) + int'(b.r)) / 2;
		res.r = s[video_pkg::color_bits-1:0];
		s = (int'(a.g) + int'(b.g)) / 2;
		res.g = s[video_pkg::color_bits-1:0];
		s = (int'(a.b) + int'(b.b)) / 2;
		res.b = s[video_pkg::color_bits-1:0];
		return res;
	endfunction

	// one input line: 64 random pixels, then 8 pixels of hsync
	// the doubled output of the previous line is checked while it runs
	task automatic drive_line(input logic smooth_on, input logic vs_level);
		logic [31:0] rnd;
		int i;
		int m;
		int p;
		int j;
		int x;
		int falls;
		int want_falls;
		video_pkg::pixel_t want;
		falls = 0;
		prev_line = cur_line;
		for (i = 0; i < active_px; i++) begin
			rnd = $urandom;
			cur_line[i] = rnd[$bits(video_pkg::pixel_t)-1:0];
		end
		for (m = 0; m < line_clocks; m++) begin
			@(posedge clk_sys);
			#2;
			p = m / clk_per_px;
			// smooth only changes on the input line start
			if (m == 0)
				smooth = smooth_on;
			vs_in = vs_level;
			ce_pix = (m % clk_per_px) == 0;
			hs_in = p >= active_px;
			pix_in = (p < active_px) ? cur_line[p] : '0;
			@(negedge clk_sys);
			compare_bit("vs_out", vs_in, vs_out);
			// hs_out falls must be exactly one output line apart
			if (hs_prev && !hs_out) begin
				falls++;
				if (last_fall >= 0)
					compare_count("hs_out fall spacing", out_line_clocks, cycle_cnt - last_fall);
				last_fall = cycle_cnt;
			end
			hs_prev = hs_out;
			// ce_x2 strobe j lands on clock 2j, its pixel shows on clock 2j+3
			if (line_no > 0 && (m % 2) == 1 && m >= 3) begin
				j = (m - 3) / 2;
				x = j % line_px;
				if (x < active_px) begin
					// second copy blends with the line now being written
					if (j >= line_px && smooth_on)
						want = avg_pixel(prev_line[x], cur_line[x]);
					else
						want = prev_line[x];
					compare_pixel("pix_out", want, pix_out);
				end
			end
		end
		// no output sync until a line is measured, the first fall ends line 1
		want_falls = (line_no == 0) ? 0 : ((line_no == 1) ? 1 : 2);
		compare_count("hs_out falls per line", want_falls, falls);
		line_no++;
	endtask

	task automatic check_after_reset;
		compare_bit("hs_out", 1'b0, hs_out);
		compare_pixel("pix_out", '0, pix_out);
	endtask

	// both copies equal the previous line
	task automatic plain_lines_test;
		repeat (4)
			drive_line(1'b0, 1'b0);
	endtask

	task automatic smooth_lines_test;
		repeat (4)
			drive_line(1'b1, 1'b0);
	endtask

	// vsync has no effect on the line path, lines keep doubling through it
	task automatic vsync_restart_test;
		repeat (2)
			drive_line(1'b0, 1'b1);
		drive_line(1'b0, 1'b0);
		drive_line(1'b1, 1'b0);
		drive_line(1'b0, 1'b0);
	endtask

	initial begin
		clk_sys = 1'b0;
		reset = 1'b1;
		ce_pix = 1'b0;
		hs_in = 1'b0;
		vs_in = 1'b0;
		smooth = 1'b0;
		pix_in = '0;
		pix_errors = 0;
		sync_errors = 0;
		line_no = 0;
		last_fall = -1;
		hs_prev = 1'b0;
		void'($urandom(32'h3e854f33));
		repeat (2) @(posedge clk_sys);
		#2;
		reset = 1'b0;
		@(negedge clk_sys);
		check_after_reset();
		plain_lines_test();
		smooth_lines_test();
		vsync_restart_test();
		$display("errors: pixel %0d, sync %0d", pix_errors, sync_errors);
		if (pix_errors + sync_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
video_pkg.sv
pix_rate_gen.sv
line_timing.sv
line_store.sv
line_doubler.sv
scandoubler.sv
scandoubler_chk.sv
scandoubler_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the scan doubler testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing --assert -Mdir "$obj" --top-module scandoubler_tb -f src.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$obj/Vscandoubler_tb" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q ">>> FAIL" "$log"; then
	echo "simulation reported failure"
	exit 1
fi
if ! grep -q ">>> PASS" "$log"; then
	echo "simulation ended without a verdict"
	exit 1
fi

echo "simulation passed"
exit 0
